/* source/nocFlitPkg.sv */
package nocFlitPkg;

  localparam int flitWidth = 32;
  localparam int idWidth = 3;
  localparam int lengthWidth = 12;

  // the id sits on top of the flit and the length just below it
  localparam int idMsb = 31;
  localparam int idLsb = 29;
  localparam int lengthMsb = 28;
  localparam int lengthLsb = 17;

  typedef logic [flitWidth-1:0] flitT;
  typedef logic [idWidth-1:0] flitIdT;
  typedef logic [lengthWidth-1:0] lengthT;  // packet length in clock periods

  localparam flitIdT headerId = 3'b001;
  localparam flitIdT bodyId = 3'b010;
  localparam flitIdT tailId = 3'b100;

endpackage

/* source/arbiterPkg.sv */
package arbiterPkg;

  localparam int numPorts = 5;  // inputs L, N, E, W, S

  // bit i+1 of the one-hot state grants input i in the order L, N, E, W, S
  typedef enum logic [5:0] {
    idle   = 6'b000001,
    grantL = 6'b000010,
    grantN = 6'b000100,
    grantE = 6'b001000,
    grantW = 6'b010000,
    grantS = 6'b100000
  } arbStateT;

endpackage

/* source/quantumTimer.sv */
`timescale 1ns/1ns

module quantumTimer
(
  input  logic               clk,
  input  logic               rst,
  input  nocFlitPkg::flitIdT flitId,
  input  nocFlitPkg::lengthT length,
  input  logic               run,
  output logic               timesUp
);

  nocFlitPkg::lengthT limit;
  nocFlitPkg::lengthT count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (flitId == nocFlitPkg::headerId)
      begin
        limit <= length;  // any header reloads the quantum whether or not the input is granted
      end
      if (!run)
      begin
        count <= '0;
      end
      else
      begin
        count <= count + 1'b1;
      end
    end
  end

  assign timesUp = (count == limit);  // so a holder keeps the port for limit+1 cycles

endmodule

/* source/outputArbiter.sv */
`timescale 1ns/1ns

module outputArbiter
(
  input  logic                 clk,
  input  logic                 rst,
  input  nocFlitPkg::flitT     lFlit,
  input  nocFlitPkg::flitT     nFlit,
  input  nocFlitPkg::flitT     eFlit,
  input  nocFlitPkg::flitT     wFlit,
  input  nocFlitPkg::flitT     sFlit,
  input  logic                 lReq,
  input  logic                 nReq,
  input  logic                 eReq,
  input  logic                 wReq,
  input  logic                 sReq,
  output arbiterPkg::arbStateT grant
);

  arbiterPkg::arbStateT state;
  arbiterPkg::arbStateT nextState;

  logic [arbiterPkg::numPorts-1:0] req;  // bit 0 is L, bit 4 is S
  logic [arbiterPkg::numPorts-1:0] run;
  logic [arbiterPkg::numPorts-1:0] timesUp;
  logic [$clog2(arbiterPkg::numPorts)-1:0] holder;

  function automatic arbiterPkg::arbStateT portGrant(input int port);
    return arbiterPkg::arbStateT'(6'b000010 << port);
  endfunction

  assign req = {sReq, wReq, eReq, nReq, lReq};

  quantumTimer lTimer
  (
    .clk     (clk),
    .rst     (rst),
    .flitId  (lFlit[nocFlitPkg::idMsb:nocFlitPkg::idLsb]),
    .length  (lFlit[nocFlitPkg::lengthMsb:nocFlitPkg::lengthLsb]),
    .run     (run[0]),
    .timesUp (timesUp[0])
  );

  quantumTimer nTimer
  (
    .clk     (clk),
    .rst     (rst),
    .flitId  (nFlit[nocFlitPkg::idMsb:nocFlitPkg::idLsb]),
    .length  (nFlit[nocFlitPkg::lengthMsb:nocFlitPkg::lengthLsb]),
    .run     (run[1]),
    .timesUp (timesUp[1])
  );

  quantumTimer eTimer
  (
    .clk     (clk),
    .rst     (rst),
    .flitId  (eFlit[nocFlitPkg::idMsb:nocFlitPkg::idLsb]),
    .length  (eFlit[nocFlitPkg::lengthMsb:nocFlitPkg::lengthLsb]),
    .run     (run[2]),
    .timesUp (timesUp[2])
  );

  quantumTimer wTimer
  (
    .clk     (clk),
    .rst     (rst),
    .flitId  (wFlit[nocFlitPkg::idMsb:nocFlitPkg::idLsb]),
    .length  (wFlit[nocFlitPkg::lengthMsb:nocFlitPkg::lengthLsb]),
    .run     (run[3]),
    .timesUp (timesUp[3])
  );

  quantumTimer sTimer
  (
    .clk     (clk),
    .rst     (rst),
    .flitId  (sFlit[nocFlitPkg::idMsb:nocFlitPkg::idLsb]),
    .length  (sFlit[nocFlitPkg::lengthMsb:nocFlitPkg::lengthLsb]),
    .run     (run[4]),
    .timesUp (timesUp[4])
  );

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= arbiterPkg::idle;
    end
    else
    begin
      state <= nextState;
    end
  end

  always_comb
  begin
    case (state)
      arbiterPkg::grantL: holder = 3'd0;
      arbiterPkg::grantN: holder = 3'd1;
      arbiterPkg::grantE: holder = 3'd2;
      arbiterPkg::grantW: holder = 3'd3;
      arbiterPkg::grantS: holder = 3'd4;
      default:            holder = 3'd0;  // not read while idle
    endcase
  end

  always_comb
  begin : nextStateLogic
    int idx;
    logic found;
    nextState = arbiterPkg::idle;
    run = '0;
    found = 1'b0;
    idx = 0;
    if (state == arbiterPkg::idle)
    begin
      for (int i = 0; i < arbiterPkg::numPorts; i++)
      begin
        if (!found && req[i])
        begin
          nextState = portGrant(i);
          found = 1'b1;
        end
      end
    end
    else if (req[holder] && !timesUp[holder])
    begin
      run[holder] = 1'b1;
      nextState = state;
    end
    else
    begin
      // search starts just after the holder, which is skipped
      for (int offset = 1; offset < arbiterPkg::numPorts; offset++)
      begin
        idx = int'(holder) + offset;
        if (idx >= arbiterPkg::numPorts)
        begin
          idx = idx - arbiterPkg::numPorts;
        end
        if (!found && req[idx])
        begin
          nextState = portGrant(idx);
          found = 1'b1;
        end
      end
    end
  end

  assign grant = state;

endmodule

/* source/outputSwitch.sv */
`timescale 1ns/1ns

module outputSwitch
(
  input  logic                 clk,
  input  logic                 rst,
  input  arbiterPkg::arbStateT grant,
  input  nocFlitPkg::flitT     lFlit,
  input  nocFlitPkg::flitT     nFlit,
  input  nocFlitPkg::flitT     eFlit,
  input  nocFlitPkg::flitT     wFlit,
  input  nocFlitPkg::flitT     sFlit,
  input  logic                 lReq,
  input  logic                 nReq,
  input  logic                 eReq,
  input  logic                 wReq,
  input  logic                 sReq,
  output nocFlitPkg::flitT     outFlit,
  output logic                 outValid
);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outFlit <= '0;
      outValid <= 1'b0;
    end
    else
    begin
      case (grant)
        arbiterPkg::grantL:
        begin
          outFlit <= lFlit;
          outValid <= lReq;  // a dropped request still gets its last grant cycle, but no strobe
        end
        arbiterPkg::grantN:
        begin
          outFlit <= nFlit;
          outValid <= nReq;
        end
        arbiterPkg::grantE:
        begin
          outFlit <= eFlit;
          outValid <= eReq;
        end
        arbiterPkg::grantW:
        begin
          outFlit <= wFlit;
          outValid <= wReq;
        end
        arbiterPkg::grantS:
        begin
          outFlit <= sFlit;
          outValid <= sReq;
        end
        default:
        begin
          outValid <= 1'b0;  // outFlit holds its last value while idle
        end
      endcase
    end
  end

endmodule

/* source/routerOutputPort.sv */
`timescale 1ns/1ns

module routerOutputPort
(
  input  logic                 clk,
  input  logic                 rst,
  input  nocFlitPkg::flitT     lFlit,
  input  nocFlitPkg::flitT     nFlit,
  input  nocFlitPkg::flitT     eFlit,
  input  nocFlitPkg::flitT     wFlit,
  input  nocFlitPkg::flitT     sFlit,
  input  logic                 lReq,
  input  logic                 nReq,
  input  logic                 eReq,
  input  logic                 wReq,
  input  logic                 sReq,
  output arbiterPkg::arbStateT grant,
  output nocFlitPkg::flitT     outFlit,
  output logic                 outValid
);

  // grant follows the requests by one cycle and the switch adds one more
  outputArbiter arbiter
  (
    .clk   (clk),
    .rst   (rst),
    .lFlit (lFlit),
    .nFlit (nFlit),
    .eFlit (eFlit),
    .wFlit (wFlit),
    .sFlit (sFlit),
    .lReq  (lReq),
    .nReq  (nReq),
    .eReq  (eReq),
    .wReq  (wReq),
    .sReq  (sReq),
    .grant (grant)
  );

  outputSwitch switch
  (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .lFlit    (lFlit),
    .nFlit    (nFlit),
    .eFlit    (eFlit),
    .wFlit    (wFlit),
    .sFlit    (sFlit),
    .lReq     (lReq),
    .nReq     (nReq),
    .eReq     (eReq),
    .wReq     (wReq),
    .sReq     (sReq),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

/* tests/routerOutputPortTb.sv */
`timescale 1ns/1ns

module routerOutputPortTb;

  localparam int numVectors = 52;
  localparam int wordsPerVector = 9;
  localparam int cycleLimit = numVectors + 20;

  logic clk = 1'b0;
  logic rst;

  nocFlitPkg::flitT lFlit;
  nocFlitPkg::flitT nFlit;
  nocFlitPkg::flitT eFlit;
  nocFlitPkg::flitT wFlit;
  nocFlitPkg::flitT sFlit;
  logic lReq;
  logic nReq;
  logic eReq;
  logic wReq;
  logic sReq;

  arbiterPkg::arbStateT grant;
  nocFlitPkg::flitT outFlit;
  logic outValid;

  // word 0 holds the requests, words 1 to 5 the flits, words 6 to 8 the expected outputs
  logic [31:0] vectorWords [0:numVectors*wordsPerVector-1];

  int cycles = 0;
  int checks = 0;
  int errors = 0;

  routerOutputPort DUT
  (
    .clk      (clk),
    .rst      (rst),
    .lFlit    (lFlit),
    .nFlit    (nFlit),
    .eFlit    (eFlit),
    .wFlit    (wFlit),
    .sFlit    (sFlit),
    .lReq     (lReq),
    .nReq     (nReq),
    .eReq     (eReq),
    .wReq     (wReq),
    .sReq     (sReq),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  always #20 clk = ~clk;

  task automatic applyInputs(input int v);
    int base;
    logic [31:0] reqWord;
    base = v * wordsPerVector;
    reqWord = vectorWords[base];
    lReq = reqWord[0];
    nReq = reqWord[1];
    eReq = reqWord[2];
    wReq = reqWord[3];
    sReq = reqWord[4];
    lFlit = vectorWords[base+1];
    nFlit = vectorWords[base+2];
    eFlit = vectorWords[base+3];
    wFlit = vectorWords[base+4];
    sFlit = vectorWords[base+5];
  endtask

  task automatic compareOutputs(input int v);
    int base;
    arbiterPkg::arbStateT expGrant;
    logic expValid;
    nocFlitPkg::flitT expFlit;
    base = v * wordsPerVector;
    expGrant = arbiterPkg::arbStateT'(vectorWords[base+6][5:0]);
    expValid = vectorWords[base+7][0];
    expFlit = vectorWords[base+8];
    checks += 3;
    assert (grant === expGrant)
    else
    begin
      $display("mismatch at %0t ns: grant expected %h, actual %h", $time, expGrant, grant);
      errors++;
    end
    assert (outValid === expValid)
    else
    begin
      $display("mismatch at %0t ns: outValid expected %b, actual %b", $time, expValid, outValid);
      errors++;
    end
    assert (outFlit === expFlit)
    else
    begin
      $display("mismatch at %0t ns: outFlit expected %h, actual %h", $time, expFlit, outFlit);
      errors++;
    end
  endtask

  task automatic printSummary();
    $display("checks: %0d, errors: %0d", checks, errors);
  endtask

  // watchdog in case the vector loop never completes
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit)
    begin
      $display("timeout: the run did not finish within %0d cycles", cycleLimit);
      errors++;
      printSummary();
      $display("** FAIL **");
      $finish;
    end
  end

  initial
  begin
    rst = 1'b1;
    lFlit = '0;
    nFlit = '0;
    eFlit = '0;
    wFlit = '0;
    sFlit = '0;
    lReq = 1'b0;
    nReq = 1'b0;
    eReq = 1'b0;
    wReq = 1'b0;
    sReq = 1'b0;
    $readmemh("tests/arbiterTests.txt", vectorWords);
    if ($isunknown(vectorWords[numVectors*wordsPerVector-1]))
    begin
      $display("the vector file tests/arbiterTests.txt is missing or holds too few vectors");
      errors++;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int v = 0; v < numVectors; v++)
    begin
      applyInputs(v);
      @(negedge clk);  // outputs settled after the rising edge in between
      compareOutputs(v);
    end
    printSummary();
    if (errors == 0)
    begin
      $display("** PASS **");
    end
    else
    begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* tests/arbiterTests.txt */
// one vector per clock cycle, all words in hex
// req{s,w,e,n,l} lFlit nFlit eFlit wFlit sFlit grant outValid outFlit
// all request from idle, fixed order with length 0 quanta
1f 40000011 40000022 40000033 40000044 40000055 02 0 00000000
1f 40000011 40000022 40000033 40000044 40000055 04 1 40000011
1f 40000011 40000022 40000033 40000044 40000055 08 1 40000022
1f 40000011 40000022 40000033 40000044 40000055 10 1 40000033
1f 40000011 40000022 40000033 40000044 40000055 20 1 40000044
1f 40000011 40000022 40000033 40000044 40000055 02 1 40000055
00 40000011 40000022 40000033 40000044 40000055 01 0 40000011
00 40000011 40000022 40000033 40000044 40000055 01 0 40000011
// east header length 3 then a held request, west header length 2 while not granted
00 40000011 40000022 200600e3 40000044 40000055 01 0 40000011
04 40000011 40000022 40000033 40000044 40000055 08 0 40000011
04 40000011 40000022 40000034 40000044 40000055 08 1 40000034
04 40000011 40000022 40000035 20040044 40000055 08 1 40000035
04 40000011 40000022 40000036 40000044 40000055 08 1 40000036
0d 40000011 40000022 40000037 40000044 40000055 10 1 40000037
09 40000011 40000022 40000033 40000044 40000055 10 1 40000044
09 40000011 40000022 40000033 40000044 40000055 10 1 40000044
09 40000011 40000022 40000033 40000044 40000055 02 1 40000044
09 40000011 40000022 40000033 40000044 40000055 10 1 40000011
// west alone times out and passes through idle, then drops early
08 40000011 40000022 40000033 40000044 40000055 10 1 40000044
08 40000011 40000022 40000033 40000044 40000055 10 1 40000044
08 40000011 40000022 40000033 40000044 40000055 01 1 40000044
08 40000011 40000022 40000033 40000044 40000055 10 0 40000044
08 40000011 40000022 40000033 40000044 40000055 10 1 40000044
02 40000011 40000022 40000033 40000044 40000055 04 0 40000044
02 40000011 40000022 40000033 40000044 40000055 01 1 40000022
// south header length 5 holds six cycles, local header length 1 while idle
00 40000011 40000022 40000033 40000044 200a0055 01 0 40000022
10 40000011 40000022 40000033 40000044 40000055 20 0 40000022
10 20020011 40000022 40000033 40000044 40000056 20 1 40000056
10 40000011 40000022 40000033 40000044 40000057 20 1 40000057
10 40000011 40000022 40000033 40000044 40000058 20 1 40000058
10 40000011 40000022 40000033 40000044 40000059 20 1 40000059
10 40000011 40000022 40000033 40000044 4000005a 20 1 4000005a
12 40000011 40000022 40000033 40000044 4000005b 04 1 4000005b
// local holds two cycles, then a length 0 header cuts it to one
03 40000011 40000022 40000033 40000044 40000055 02 1 40000022
03 40000011 40000022 40000033 40000044 40000055 02 1 40000011
03 40000011 40000022 40000033 40000044 40000055 04 1 40000011
03 20000011 40000022 40000033 40000044 40000055 02 1 40000022
03 40000011 40000022 40000033 40000044 40000055 04 1 40000011
00 40000011 40000022 40000033 40000044 40000055 01 0 40000022
00 40000011 40000022 40000033 40000044 40000055 01 0 40000022
// east, west and south from idle with dropped holders
1c 40000011 40000022 40000033 40000044 40000055 08 0 40000022
1c 40000011 40000022 40000033 40000044 40000055 08 1 40000033
18 40000011 40000022 40000033 40000044 40000055 10 0 40000033
18 40000011 40000022 40000033 40000044 40000055 10 1 40000044
18 40000011 40000022 40000033 40000044 40000055 10 1 40000044
18 40000011 40000022 40000033 40000044 40000055 20 1 40000044
09 40000011 40000022 40000033 40000044 40000055 02 0 40000055
09 40000011 40000022 40000033 40000044 40000055 10 1 40000011
08 40000011 40000022 40000033 40000044 40000055 10 1 40000044
08 40000011 40000022 40000033 40000044 40000055 10 1 40000044
08 40000011 40000022 40000033 40000044 40000055 01 1 40000044
00 40000011 40000022 40000033 40000044 40000055 01 0 40000044

/* sim.f */
source/nocFlitPkg.sv
source/arbiterPkg.sv
source/quantumTimer.sv
source/outputArbiter.sv
source/outputSwitch.sv
source/routerOutputPort.sv
tests/routerOutputPortTb.sv

/* Bender.yml */
package:
  name: router_output_port

sources:
  # packages first, the RTL depends on them
  - source/nocFlitPkg.sv
  - source/arbiterPkg.sv
  # RTL, leaf modules before the top level
  - source/quantumTimer.sv
  - source/outputArbiter.sv
  - source/outputSwitch.sv
  - source/routerOutputPort.sv
  # testbench
  - target: test
    files:
      - tests/routerOutputPortTb.sv
